// File: zx_memory.f
rtl/zx_mem_pkg.sv
rtl/cpu_bus_if.sv
rtl/mem_map_if.sv
rtl/bank_registers.sv
rtl/divmmc_control.sv
rtl/sram_address_mapper.sv
rtl/zx_memory_top.sv
test/tb_zx_memory.sv

// File: Bender.yml
package:
  name: zx_memory

sources:
  - rtl/zx_mem_pkg.sv
  - rtl/cpu_bus_if.sv
  - rtl/mem_map_if.sv
  - rtl/bank_registers.sv
  - rtl/divmmc_control.sv
  - rtl/sram_address_mapper.sv
  - rtl/zx_memory_top.sv
  - target: test
    files:
      - test/tb_zx_memory.sv

// File: test/tb_zx_memory.sv
`timescale 1ns/1ns

module tb_zx_memory;

   logic        clk;
   logic        mrst_n;
   logic [15:0] a;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        oe_n;
   logic        mreq_n, iorq_n, rd_n, wr_n, m1_n;
   logic        divmmc_enabled;
   logic        nmi_disabled;
   logic        enable_nmi_n;
   logic        access_to_screen;
   logic [18:0] sram_addr;
   logic        sram_we_n;
   logic [7:0]  sram_wdata;
   logic [7:0]  sram_rdata;

   // Reference model of the paging state
   logic [2:0] exp_ram;
   logic [1:0] exp_rom;      // {1FFD bit 2, 7FFD bit 4}
   logic       exp_allram;
   logic [1:0] exp_layout;
   logic       exp_locked;
   logic       exp_conmem, exp_mapram;
   logic [3:0] exp_page;
   logic       exp_pending, exp_paged;
   int         cycles = 0;

   zx_memory_top #(.plus3_decode(1'b1)) zx_memory_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 125 MHz
   end

   // Whole run needs a few hundred cycles
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= 2000) begin
         $display("Timeout: run did not finish within 2000 cycles");
         $display("TEST FAIL");
         $fatal(1);
      end
   end

   //------------------------------------------------------------
   // Expected values
   //------------------------------------------------------------
   function automatic logic [2:0] allram_slot_page(input logic [1:0] layout,
                                                   input logic [1:0] slot);
      logic [11:0] pages;  // Slot 0 in the low bits
      case (layout)
         2'd0:    pages = {3'd3, 3'd2, 3'd1, 3'd0};
         2'd1:    pages = {3'd7, 3'd6, 3'd5, 3'd4};
         2'd2:    pages = {3'd3, 3'd6, 3'd5, 3'd4};
         default: pages = {3'd3, 3'd6, 3'd7, 3'd4};
      endcase
      return pages[slot*3 +: 3];
   endfunction

   // Returns {write protect, SRAM address}
   function automatic logic [19:0] expected_map(input logic [15:0] addr);
      logic [18:0] base;
      logic        prot;
      logic [2:0]  page;
      if (addr[15:14] == 2'd0 && divmmc_enabled && (exp_paged || exp_conmem)) begin
         if (addr < 16'h2000) begin
            base = (exp_mapram && !exp_conmem) ? 19'h46000 : 19'h30000;
            prot = 1'b1;
         end else begin
            base = 19'h40000 + exp_page * 19'h2000;
            prot = exp_mapram && exp_page == 4'd3;
         end
         return {prot, base + addr[12:0]};
      end
      if (addr[15:14] == 2'd0 && !exp_allram)
         return {1'b1, 19'h20000 + exp_rom * 19'h4000 + addr[13:0]};  // ROM
      if (exp_allram)
         page = allram_slot_page(exp_layout, addr[15:14]);
      else if (addr[15:14] == 2'd1)
         page = 3'd5;
      else if (addr[15:14] == 2'd2)
         page = 3'd2;
      else
         page = exp_ram;
      return {1'b0, page * 19'h4000 + addr[13:0]};
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("mismatch at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
         $display("TEST FAIL");
         $fatal(1);
      end
   endtask

   task automatic check_outputs;
      logic [19:0] em;
      logic        screen;
      em     = expected_map(a);
      screen = !exp_allram && (a[15:14] == 2'd1 ||
                               (a[15:14] == 2'd3 && (exp_ram == 3'd5 || exp_ram == 3'd7)));
      check_value("sram_addr", em[18:0], sram_addr);
      check_value("sram_we_n", mreq_n | wr_n | em[19], sram_we_n);
      check_value("oe_n", mreq_n | rd_n, oe_n);
      check_value("access_to_screen", screen, access_to_screen);
      check_value("enable_nmi_n", divmmc_enabled & exp_paged & ~nmi_disabled, enable_nmi_n);
      check_value("dout", sram_rdata, dout);
      check_value("sram_wdata", din, sram_wdata);
   endtask

   //------------------------------------------------------------
   // Bus cycles driven on the falling edge
   //------------------------------------------------------------
   task automatic apply_reset;
      mrst_n = 1'b0;
      repeat (5) @(negedge clk);  // Five rising edges with mrst_n low
      mrst_n = 1'b1;
      {exp_ram, exp_rom, exp_allram, exp_layout, exp_locked} = '0;
      {exp_conmem, exp_mapram, exp_page, exp_pending, exp_paged} = '0;
   endtask

   task automatic mem_access(input logic [15:0] addr, input logic write);
      @(negedge clk);
      a          = addr;
      din        = $urandom();
      sram_rdata = $urandom();
      {mreq_n, iorq_n, m1_n} = 3'b011;
      rd_n       = write;
      wr_n       = !write;
      #2 check_outputs();  // Address path is combinational
   endtask

   task automatic port_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge clk);
      a   = addr;
      din = data;
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b10101;
      @(negedge clk);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      if (!exp_locked) begin
         if (!addr[1] && addr[15:14] == 2'b01) begin  // 7FFD
            exp_ram    = data[2:0];
            exp_rom[0] = data[4];
            exp_locked = data[5];
         end
         if (!addr[1] && addr[15:12] == 4'b0001) begin  // 1FFD
            exp_allram = data[0];
            exp_layout = data[2:1];
            exp_rom[1] = data[2];
         end
      end
      if (addr[7:0] == 8'he3)
         {exp_conmem, exp_mapram, exp_page} = {data[7:6], data[3:0]};
      #2 check_outputs();
   endtask

   task automatic m1_fetch(input logic [15:0] addr);
      @(negedge clk);
      a = addr;
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b01010;
      #2 check_outputs();  // Old mapping during the fetch
      @(posedge clk);
      if (addr[15:8] == 8'h3d) begin
         exp_paged   = 1'b1;  // Instant entry
         exp_pending = 1'b1;
      end else if (addr >= 16'h1ff8 && addr <= 16'h1fff)
         exp_pending = 1'b0;
      else if (addr == 16'h0000 || addr == 16'h0008 || addr == 16'h0038 ||
               addr == 16'h04c6 || addr == 16'h0562 || (addr == 16'h0066 && !nmi_disabled))
         exp_pending = 1'b1;
      #2 check_outputs();
      @(negedge clk);
      {mreq_n, rd_n, m1_n} = 3'b111;
      @(posedge clk);
      exp_paged = exp_pending;  // Deferred events land once M1 is high
      #2 check_outputs();
   endtask

   task automatic sweep_slots;
      for (int s = 0; s < 4; s++)
         mem_access({s[1:0], 14'($urandom())}, 1'b0);
   endtask

   task automatic divmmc_accesses;
      logic [12:0] off;
      off = $urandom();
      mem_access({3'b000, off}, 1'b0);
      mem_access({3'b000, off}, 1'b1);  // Write to the read-only ROM side
      off = $urandom();
      mem_access({3'b001, off}, 1'b1);
   endtask

   //------------------------------------------------------------
   // Stimulus
   //------------------------------------------------------------
   initial begin
      void'($urandom(32'h0c9f7b4b));
      a = '0;
      din = '0;
      sram_rdata = '0;
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
      divmmc_enabled = 1'b0;
      nmi_disabled   = 1'b0;
      mrst_n         = 1'b0;
      apply_reset();

      sweep_slots();  // Reset mapping
      mem_access({2'b00, 14'($urandom())}, 1'b1);

      port_write(16'h7ffd, 8'h15);  // Page 5, ROM 1
      sweep_slots();
      port_write(16'h7ffd, 8'h07);
      sweep_slots();
      port_write(16'h7ffd, 8'h03);
      sweep_slots();

      for (int l = 0; l < 4; l++) begin
         port_write(16'h1ffd, {5'b0, l[1:0], 1'b1});  // All-RAM layouts
         sweep_slots();
      end
      port_write(16'h1ffd, 8'h04);  // ROM bank high bit
      sweep_slots();
      port_write(16'h1ffd, 8'h00);

      @(negedge clk) divmmc_enabled = 1'b1;
      port_write(16'h00e3, 8'h85);  // conmem, page 5
      divmmc_accesses();
      port_write(16'h00e3, 8'hc3);  // mapram page 3 read-only
      divmmc_accesses();
      port_write(16'h00e3, 8'h02);

      m1_fetch(16'h0038);
      divmmc_accesses();
      m1_fetch(16'h1ff8);
      divmmc_accesses();
      m1_fetch(16'h3d00);
      port_write(16'h00e3, 8'h41);  // mapram while paged
      divmmc_accesses();
      m1_fetch(16'h1ffc);
      @(negedge clk) nmi_disabled = 1'b1;
      m1_fetch(16'h0066);           // NMI entry blocked
      divmmc_accesses();
      m1_fetch(16'h0000);           // Paged in while NMI is disabled

      port_write(16'h7ffd, 8'h21);  // Lock paging
      port_write(16'h7ffd, 8'h07);
      port_write(16'h1ffd, 8'h01);
      sweep_slots();

      $display("TEST PASS");
      $finish;
   end

endmodule

// File: rtl/zx_memory_top.sv
`timescale 1ns/1ns

module zx_memory_top #(
   parameter bit plus3_decode = 1'b1  // 1 for +2A/+3, 0 for 128K
) (
   input  logic clk,
   input  logic mrst_n,

   // Z80 bus
   input  logic [zx_mem_pkg::cpu_addr_w-1:0] a,
   input  logic [zx_mem_pkg::data_w-1:0]     din,
   output logic [zx_mem_pkg::data_w-1:0]     dout,
   output logic oe_n,
   input  logic mreq_n,
   input  logic iorq_n,
   input  logic rd_n,
   input  logic wr_n,
   input  logic m1_n,

   // DivMMC options
   input  logic divmmc_enabled,
   input  logic nmi_disabled,
   output logic enable_nmi_n,
   output logic access_to_screen,  // To the ULA contention logic

   // External SRAM, split data buses
   output logic [zx_mem_pkg::sram_addr_w-1:0] sram_addr,
   output logic                               sram_we_n,
   output logic [zx_mem_pkg::data_w-1:0]     sram_wdata,
   input  logic [zx_mem_pkg::data_w-1:0]     sram_rdata
);

   cpu_bus_if bus ();
   mem_map_if map ();

   // Bundle the CPU bus
   assign bus.a      = a;
   assign bus.din    = din;
   assign bus.mreq_n = mreq_n;
   assign bus.iorq_n = iorq_n;
   assign bus.rd_n   = rd_n;
   assign bus.wr_n   = wr_n;
   assign bus.m1_n   = m1_n;

   // Data passes straight between CPU and SRAM
   assign sram_wdata = din;
   assign dout       = sram_rdata;

   //------------------------------------------------------------
   // Paging blocks
   //------------------------------------------------------------
   bank_registers #(
      .plus3_decode (plus3_decode)
   ) bank_registers_inst (
      .clk    (clk),
      .mrst_n (mrst_n),
      .bus    (bus.sink),
      .map    (map.paging_src)
   );

   divmmc_control divmmc_control_inst (
      .clk          (clk),
      .mrst_n       (mrst_n),
      .nmi_disabled (nmi_disabled),
      .bus          (bus.sink),
      .map          (map.divmmc_src)
   );

   sram_address_mapper sram_address_mapper_inst (
      .divmmc_enabled   (divmmc_enabled),
      .nmi_disabled     (nmi_disabled),
      .bus              (bus.sink),
      .map              (map.map_sink),
      .sram_addr        (sram_addr),
      .sram_we_n        (sram_we_n),
      .oe_n             (oe_n),
      .access_to_screen (access_to_screen),
      .enable_nmi_n     (enable_nmi_n)
   );

endmodule

// File: rtl/sram_address_mapper.sv
`timescale 1ns/1ns

module sram_address_mapper (
   input  logic        divmmc_enabled,
   input  logic        nmi_disabled,
   cpu_bus_if.sink     bus,
   mem_map_if.map_sink map,
   output logic [zx_mem_pkg::sram_addr_w-1:0] sram_addr,
   output logic        sram_we_n,
   output logic        oe_n,
   output logic        access_to_screen,
   output logic        enable_nmi_n
);

   logic [1:0]            slot;       // 16K slot of the CPU address
   logic                  dm_active;  // DivMMC overlays slot 0
   logic                  protect;    // Region is read-only
   zx_mem_pkg::ram_page_e page;

   // Page held by each slot in the +2A all-RAM modes
   function automatic zx_mem_pkg::ram_page_e allram_page(
      input zx_mem_pkg::plus3_layout_e layout,
      input logic [1:0]                slot_no
   );
      zx_mem_pkg::ram_page_e p;
      case (slot_no)
         2'd0: p = (layout == zx_mem_pkg::layout_0) ? zx_mem_pkg::page0 : zx_mem_pkg::page4;
         2'd1: begin
            case (layout)
               zx_mem_pkg::layout_0: p = zx_mem_pkg::page1;
               zx_mem_pkg::layout_3: p = zx_mem_pkg::page7;
               default:              p = zx_mem_pkg::page5;
            endcase
         end
         2'd2: p = (layout == zx_mem_pkg::layout_0) ? zx_mem_pkg::page2 : zx_mem_pkg::page6;
         default: p = (layout == zx_mem_pkg::layout_1) ? zx_mem_pkg::page7 : zx_mem_pkg::page3;
      endcase
      return p;
   endfunction

   assign slot      = bus.a[15:14];
   assign dm_active = divmmc_enabled && (map.dm_paged || map.dm_conmem);

   //------------------------------------------------------------
   // Address translation
   //------------------------------------------------------------
   always_comb begin
      protect   = 1'b0;
      page      = zx_mem_pkg::page0;
      sram_addr = '0;
      if (slot == 2'd0 && dm_active) begin
         if (!bus.a[13]) begin  // 0000-1FFF, DivMMC ROM side
            protect = 1'b1;
            if (map.dm_mapram && !map.dm_conmem)
               sram_addr = zx_mem_pkg::divmmc_mapram_base | {6'b0, bus.a[12:0]};
            else
               sram_addr = zx_mem_pkg::divmmc_rom_base | {6'b0, bus.a[12:0]};
         end else begin  // 2000-3FFF, banked DivMMC RAM
            sram_addr = zx_mem_pkg::divmmc_ram_base | {2'b0, map.dm_page, bus.a[12:0]};
            protect   = map.dm_mapram && map.dm_page == 4'd3;  // Page 3 acts as ROM
         end
      end else if (slot == 2'd0 && !map.allram) begin
         sram_addr = zx_mem_pkg::rom_base_page | {3'b0, map.rom_bank, bus.a[13:0]};
         protect   = 1'b1;
      end else begin
         if (map.allram)
            page = allram_page(map.layout, slot);
         else begin
            case (slot)
               2'd1:    page = zx_mem_pkg::page5;
               2'd2:    page = zx_mem_pkg::page2;
               default: page = map.ram_bank;  // Slot 3 follows 7FFD
            endcase
         end
         sram_addr = {2'b00, page, bus.a[13:0]};
      end
   end

   //------------------------------------------------------------
   // Strobes and flags
   //------------------------------------------------------------
   assign sram_we_n = bus.mreq_n | bus.wr_n | protect;
   assign oe_n      = bus.mreq_n | bus.rd_n;

   // Contention applies to the screen pages 5 and 7 in normal paging
   assign access_to_screen = !map.allram &&
                             (slot == 2'd1 ||
                              (slot == 2'd3 && (map.ram_bank == zx_mem_pkg::page5 ||
                                                map.ram_bank == zx_mem_pkg::page7)));

   assign enable_nmi_n = divmmc_enabled & map.dm_paged & ~nmi_disabled;

endmodule

// File: rtl/divmmc_control.sv
`timescale 1ns/1ns

module divmmc_control (
   input  logic          clk,
   input  logic          mrst_n,
   input  logic          nmi_disabled,  // Blocks the 0066 entry point
   cpu_bus_if.sink       bus,
   mem_map_if.divmmc_src map
);

   logic       e3_wr;
   logic       conmem_q;
   logic       mapram_q;
   logic [3:0] page_q;

   logic                       m1_fetch;
   zx_mem_pkg::automap_event_e am_event;
   logic                       pending_q;  // State to apply once M1 ends
   logic                       paged_q;

   //------------------------------------------------------------
   // Port E3
   //------------------------------------------------------------
   assign e3_wr = !bus.iorq_n && !bus.wr_n && bus.a[7:0] == zx_mem_pkg::port_divmmc;

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         conmem_q <= 1'b0;
         mapram_q <= 1'b0;
         page_q   <= 4'h0;
      end else if (e3_wr) begin
         conmem_q <= bus.din[7];
         mapram_q <= bus.din[6];  // Bits 5-4 are not used
         page_q   <= bus.din[3:0];
      end
   end

   //------------------------------------------------------------
   // Automapper
   //------------------------------------------------------------
   assign m1_fetch = !bus.mreq_n && !bus.rd_n && !bus.m1_n;

   // Entry and exit points of the DivMMC firmware
   always_comb begin
      am_event = zx_mem_pkg::am_none;
      if (m1_fetch) begin
         if (bus.a[15:8] == 8'h3d)
            am_event = zx_mem_pkg::am_instant_on;    // TR-DOS style entry
         else if (bus.a[15:3] == 13'h03ff)
            am_event = zx_mem_pkg::am_deferred_off;  // 1FF8-1FFF
         else begin
            case (bus.a)
               16'h0000, 16'h0008, 16'h0038,
               16'h04c6, 16'h0562:
                  am_event = zx_mem_pkg::am_deferred_on;
               16'h0066:
                  if (!nmi_disabled)
                     am_event = zx_mem_pkg::am_deferred_on;  // NMI entry
               default: am_event = zx_mem_pkg::am_none;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         pending_q <= 1'b0;
         paged_q   <= 1'b0;
      end else begin
         case (am_event)
            zx_mem_pkg::am_deferred_on:  pending_q <= 1'b1;
            zx_mem_pkg::am_instant_on: begin
               paged_q   <= 1'b1;  // Takes effect on this very fetch
               pending_q <= 1'b1;
            end
            zx_mem_pkg::am_deferred_off: pending_q <= 1'b0;
            default: ;
         endcase
         if (bus.m1_n)
            paged_q <= pending_q;  // Mapping changes only outside M1
      end
   end

   assign map.dm_paged  = paged_q;
   assign map.dm_conmem = conmem_q;
   assign map.dm_mapram = mapram_q;
   assign map.dm_page   = page_q;

endmodule

// File: rtl/bank_registers.sv
`timescale 1ns/1ns

module bank_registers #(
   parameter bit plus3_decode = 1'b1  // 0 selects plain 128K decoding
) (
   input  logic         clk,
   input  logic         mrst_n,
   cpu_bus_if.sink      bus,
   mem_map_if.paging_src map
);

   logic       port_wr;   // I/O write cycle on the bus
   logic       sel_7ffd;
   logic       sel_1ffd;
   logic       locked;    // 7FFD bit 5

   logic [2:0] ram_q;     // 7FFD bits 2-0
   logic       rom_lo_q;  // 7FFD bit 4
   logic [2:0] plus3_q;   // 1FFD bits 2-0

   //------------------------------------------------------------
   // Port decoding
   //------------------------------------------------------------
   assign port_wr = !bus.iorq_n && !bus.wr_n;

   // +2A decodes more address lines so 1FFD can coexist with 7FFD
   assign sel_7ffd = plus3_decode ? (!bus.a[1] && bus.a[15:14] == 2'b01)
                                  : (!bus.a[1] && !bus.a[15]);
   assign sel_1ffd = plus3_decode && !bus.a[1] && bus.a[15:12] == 4'b0001;  // None on 128K

   //------------------------------------------------------------
   // Registers
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         ram_q    <= 3'b000;
         rom_lo_q <= 1'b0;
         locked   <= 1'b0;
         plus3_q  <= 3'b000;
      end else if (port_wr && !locked) begin  // Lock freezes both ports until reset
         if (sel_7ffd) begin
            ram_q    <= bus.din[2:0];
            rom_lo_q <= bus.din[4];
            locked   <= bus.din[5];
         end
         if (sel_1ffd)
            plus3_q <= bus.din[2:0];
      end
   end

   // Published paging state
   assign map.ram_bank = zx_mem_pkg::ram_page_e'(ram_q);
   assign map.rom_bank = {plus3_q[2], rom_lo_q};  // High ROM bit comes from 1FFD
   assign map.allram   = plus3_q[0];
   assign map.layout   = zx_mem_pkg::plus3_layout_e'(plus3_q[2:1]);

endmodule

// File: rtl/mem_map_if.sv
`timescale 1ns/1ns

interface mem_map_if;

   // 128K / +2A paging state
   zx_mem_pkg::ram_page_e     ram_bank;  // Page in slot 3
   logic [1:0]                rom_bank;  // One of four 16K ROMs
   logic                      allram;    // +2A special paging
   zx_mem_pkg::plus3_layout_e layout;

   // DivMMC state
   logic       dm_paged;   // Automapper has mapped DivMMC in
   logic       dm_conmem;  // Forced mapping from E3 bit 7
   logic       dm_mapram;  // E3 bit 6
   logic [3:0] dm_page;    // 8K RAM page at 2000-3FFF

   modport paging_src (
      output ram_bank,
      output rom_bank,
      output allram,
      output layout
   );

   modport divmmc_src (
      output dm_paged,
      output dm_conmem,
      output dm_mapram,
      output dm_page
   );

   modport map_sink (
      input ram_bank, rom_bank, allram, layout,
      input dm_paged, dm_conmem, dm_mapram, dm_page
   );

endinterface

// File: rtl/cpu_bus_if.sv
`timescale 1ns/1ns

interface cpu_bus_if;

   // Z80 address and write data
   logic [zx_mem_pkg::cpu_addr_w-1:0] a;
   logic [zx_mem_pkg::data_w-1:0]     din;

   // Bus strobes, all active low
   logic mreq_n;  // Memory access
   logic iorq_n;  // Port access
   logic rd_n;
   logic wr_n;
   logic m1_n;    // Opcode fetch

   // Paging logic only observes the bus
   modport sink (
      input a,
      input din,
      input mreq_n,
      input iorq_n,
      input rd_n,
      input wr_n,
      input m1_n
   );

endinterface

// File: rtl/zx_mem_pkg.sv
package zx_mem_pkg;

   //------------------------------------------------------------
   // Bus widths
   //------------------------------------------------------------
   localparam int cpu_addr_w  = 16;  // Z80 address bus
   localparam int sram_addr_w = 19;  // 512K external SRAM
   localparam int data_w      = 8;

   // DivMMC control port, only the low byte is decoded
   localparam logic [7:0] port_divmmc = 8'he3;

   //------------------------------------------------------------
   // Page and event encodings
   //------------------------------------------------------------
   typedef enum logic [2:0] {
      page0, page1, page2, page3,
      page4, page5, page6, page7  // Pages 5 and 7 hold the screens
   } ram_page_e;

   // +2A/+3 all-RAM arrangements, from 1FFD bits 2-1
   typedef enum logic [1:0] {
      layout_0,  // 0-1-2-3
      layout_1,  // 4-5-6-7
      layout_2,  // 4-5-6-3
      layout_3   // 4-7-6-3
   } plus3_layout_e;

   typedef enum logic [1:0] {
      am_none,
      am_deferred_on,   // Map after the M1 cycle
      am_instant_on,    // Map during the current fetch
      am_deferred_off   // Unmap after the M1 cycle
   } automap_event_e;

   //------------------------------------------------------------
   // Upper address bits of the SRAM regions
   //------------------------------------------------------------
   localparam logic [sram_addr_w-1:0] rom_base_page      = 19'h20000;  // Four 16K ROMs
   localparam logic [sram_addr_w-1:0] divmmc_rom_base    = 19'h30000;  // 8K DivMMC EEPROM
   localparam logic [sram_addr_w-1:0] divmmc_mapram_base = 19'h46000;  // DivMMC RAM page 3
   localparam logic [sram_addr_w-1:0] divmmc_ram_base    = 19'h40000;  // Sixteen 8K pages

endpackage
